/* Bender.yml */
package:
  name: uart_cmd_link

export_include_dirs:
  - hw

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/cmd_pkg.sv
      - hw/cmd_framer.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/uart_top.sv
  - target: simulation
    files:
      - sim/uart_checker.sv
      - sim/uart_sva.sv
      - sim/uart_tb.sv

/* hw/cmd_framer.sv */
`include "uart_macros.svh"

module cmd_framer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::cmd_word_t   cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 byte_start,
  output cmd_pkg::uart_byte_t  byte_data,
  input  logic                 byte_done
);

  import cmd_pkg::*;

  cmd_word_t cmd_q;
  logic      low_sel;
  logic      accept;

  assign accept = cmd_vld && cmd_rdy;

  // the command is held here for both frames
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rdy    <= 1'b1;
      byte_start <= 1'b0;
      low_sel    <= 1'b0;
    end else begin
      byte_start <= 1'b0;
      if (accept) begin
        cmd_rdy    <= 1'b0;
        low_sel    <= 1'b0;
        byte_start <= 1'b1;
      end else if (byte_done) begin
        if (!low_sel) begin
          // high byte is out, the low byte follows right away
          low_sel    <= 1'b1;
          byte_start <= 1'b1;
        end else begin
          low_sel <= 1'b0;
          cmd_rdy <= 1'b1;
        end
      end
    end
  end

  assign byte_data = low_sel ? cmd_q[7:0] : cmd_q[`UART_CMD_WIDTH-1 -: 8];

endmodule

/* hw/cmd_pkg.sv */
`include "uart_macros.svh"

package cmd_pkg;

  // command word as accepted from the host
  typedef logic [`UART_CMD_WIDTH-1:0] cmd_word_t;

  // one byte on the serial line
  typedef logic [7:0] uart_byte_t;

  // received byte with the parity error flag on top
  typedef logic [`UART_READ_WIDTH:0] read_word_t;

endpackage

/* hw/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// width of one command word from the host side
`define UART_CMD_WIDTH 16

// width of the received data byte, without the parity error flag
`define UART_READ_WIDTH 8

// clock cycles per serial bit unless a module overrides it
`define UART_CLKS_PER_BIT 16

`endif

/* hw/uart_pkg.sv */
package uart_pkg;

  // data bits in one serial frame
  localparam int unsigned DATA_BITS = 8;

  // part of the frame that is currently on the line
  typedef enum logic [2:0] {
    PH_IDLE   = 3'd0,
    PH_START  = 3'd1,
    PH_DATA   = 3'd2,
    PH_PARITY = 3'd3,
    PH_STOP   = 3'd4
  } frame_phase_e;

endpackage

/* hw/uart_rx.sv */
`include "uart_macros.svh"

module uart_rx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output cmd_pkg::read_word_t read_data,
  output logic                read_rdy
);

  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit);
  localparam int HALF  = clks_per_bit / 2;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  frame_phase_e     phase_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  uart_byte_t       data_q;
  logic             par_q;
  logic             bit_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign bit_end = (cnt_q == CNT_W'(clks_per_bit - 1));

  // payload registers, loaded at each data or parity sample
  always_ff @(posedge clk) begin
    if (bit_end && phase_q == PH_DATA) begin
      data_q <= {rx_sync, data_q[7:1]};
    end
    if (bit_end && phase_q == PH_PARITY) begin
      par_q <= rx_sync;
    end
    if (bit_end && phase_q == PH_STOP && rx_sync) begin
      // flag is set when data and parity together hold an even count of ones
      read_data <= {~(^data_q ^ par_q), data_q};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q   <= PH_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      read_rdy  <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      cnt_q    <= cnt_q + 1'b1;
      case (phase_q)
        PH_IDLE: begin
          cnt_q <= '0;
          if (rx_prev && !rx_sync) begin
            phase_q <= PH_START;
          end
        end
        PH_START: begin
          // a glitch shorter than half a bit is not a start bit
          if (cnt_q == CNT_W'(HALF - 1)) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            phase_q   <= rx_sync ? PH_IDLE : PH_DATA;
          end
        end
        PH_DATA: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'(DATA_BITS - 1)) begin
              phase_q <= PH_PARITY;
            end
          end
        end
        PH_PARITY: begin
          if (bit_end) begin
            cnt_q   <= '0;
            phase_q <= PH_STOP;
          end
        end
        default: begin
          if (bit_end) begin
            cnt_q    <= '0;
            phase_q  <= PH_IDLE;
            read_rdy <= rx_sync;
          end
        end
      endcase
    end
  end

endmodule

/* hw/uart_top.sv */
`include "uart_macros.svh"

module uart_top #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                clk,
  input  logic                rst_n,
  input  cmd_pkg::cmd_word_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output cmd_pkg::read_word_t read_data,
  output logic                read_rdy
);

  import cmd_pkg::*;

  logic       byte_start;
  uart_byte_t byte_data;
  logic       byte_done;

  // splits each command into two bytes, high byte first
  cmd_framer i_cmd_framer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_start(byte_start),
    .byte_data (byte_data),
    .byte_done (byte_done)
  );

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_start(byte_start),
    .byte_data (byte_data),
    .tx        (tx),
    .byte_done (byte_done)
  );

  // the receiver runs on its own and does not depend on the transmit side
  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .read_data(read_data),
    .read_rdy (read_rdy)
  );

endmodule

/* hw/uart_tx.sv */
`include "uart_macros.svh"

module uart_tx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 byte_start,
  input  cmd_pkg::uart_byte_t  byte_data,
  output logic                 tx,
  output logic                 byte_done
);

  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit);

  frame_phase_e     phase_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  uart_byte_t       data_q;
  logic             bit_end;

  assign bit_end   = (cnt_q == CNT_W'(clks_per_bit - 1));
  assign byte_done = (phase_q == PH_STOP) && bit_end;

  always_ff @(posedge clk) begin
    if (byte_start) begin
      data_q <= byte_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q   <= PH_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx        <= 1'b1;
    end else if (phase_q == PH_IDLE) begin
      cnt_q <= '0;
      if (byte_start) begin
        phase_q <= PH_START;
        tx      <= 1'b0;
      end
    end else if (!bit_end) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      cnt_q <= '0;
      case (phase_q)
        PH_START: begin
          phase_q   <= PH_DATA;
          bit_idx_q <= '0;
          tx        <= data_q[0];
        end
        PH_DATA: begin
          if (bit_idx_q == 3'(DATA_BITS - 1)) begin
            // odd parity, so the bit is set when the data has an even count
            phase_q <= PH_PARITY;
            tx      <= ~^data_q;
          end else begin
            bit_idx_q <= bit_idx_q + 3'd1;
            tx        <= data_q[bit_idx_q + 3'd1];
          end
        end
        PH_PARITY: begin
          phase_q <= PH_STOP;
          tx      <= 1'b1;
        end
        default: begin
          phase_q <= PH_IDLE;
          tx      <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* sim/uart_checker.sv */
module uart_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                tx,
  input logic                cmd_rdy,
  input cmd_pkg::read_word_t read_data,
  input logic                read_rdy
);

  import cmd_pkg::*;

  read_word_t expected_q[$];
  int         err_count    = 0;
  bit         idle_checked = 1'b0;

  task automatic push_expected(input read_word_t word);
    expected_q.push_back(word);
  endtask

  function automatic int pending();
    return expected_q.size();
  endfunction

  // the first edge after reset release still shows the reset values
  always @(posedge clk) begin
    if (rst_n && !idle_checked) begin
      idle_checked = 1'b1;
      if (tx !== 1'b1 || read_rdy !== 1'b0 || cmd_rdy !== 1'b1) begin
        $display("[ERROR] %0t: idle state wrong, tx=%b read_rdy=%b cmd_rdy=%b",
                 $time, tx, read_rdy, cmd_rdy);
        err_count++;
      end
    end
  end

  always @(posedge clk) begin
    read_word_t exp_word;
    if (rst_n && read_rdy === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("[ERROR] %0t: read word %h arrived with nothing expected", $time, read_data);
        err_count++;
      end else begin
        exp_word = expected_q.pop_front();
        if (read_data !== exp_word) begin
          $display("[ERROR] %0t: read_data %h, expected %h", $time, read_data, exp_word);
          err_count++;
        end
      end
    end
  end

endmodule

/* sim/uart_sva.sv */
module uart_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic tx_idle,
  input logic byte_done,
  input logic read_rdy
);

  int fail_count = 0;

  // an open cmd_rdy means both frames are out and the line is back at idle
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> (tx_idle && tx))
    else begin
      $error("transmitter busy or tx low while cmd_rdy is high");
      fail_count++;
    end

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      $error("read_rdy lasted two cycles");
      fail_count++;
    end

  // both frames must finish before the next command can be taken
  rdy_low_two_frames: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> (!cmd_rdy throughout byte_done [-> 2]))
    else begin
      $error("cmd_rdy rose before both bytes were sent");
      fail_count++;
    end

endmodule

bind uart_top uart_sva i_uart_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .tx_idle  (i_uart_tx.phase_q == uart_pkg::PH_IDLE),
  .byte_done(byte_done),
  .read_rdy (read_rdy)
);

/* sim/uart_tb.sv */
`include "uart_macros.svh"

module uart_tb;

  import cmd_pkg::*;

  localparam int          CPB       = `UART_CLKS_PER_BIT;
  localparam int          TIMEOUT   = 30 * CPB;
  localparam int unsigned RAND_SEED = 32'hd237;

  logic       clk;
  logic       rst_n;
  cmd_word_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       tx;
  logic       rx_line;
  logic       use_gen;
  logic       gen_line;
  read_word_t read_data;
  logic       read_rdy;
  int         timeouts = 0;
  int         missing;
  int         sva_fails;
  cmd_word_t  patterns[5] = '{16'h0000, 16'hFFFF, 16'hAAAA, 16'h5555, 16'h01FE};

  // rx sees either the looped-back tx line or the frame generator
  assign rx_line = use_gen ? gen_line : tx;

  uart_top i_uart_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx_line),
    .tx       (tx),
    .read_data(read_data),
    .read_rdy (read_rdy)
  );

  uart_checker i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .cmd_rdy  (cmd_rdy),
    .read_data(read_data),
    .read_rdy (read_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // a correct sender sets the parity bit when the data holds an even count of ones
  function automatic logic odd_parity_bit(input uart_byte_t data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++) begin
      ones += data[i];
    end
    return (ones % 2 == 0);
  endfunction

  function automatic read_word_t expected_word(input uart_byte_t data, input bit bad_parity);
    int   ones;
    int   i;
    logic par_bit;
    ones    = 0;
    par_bit = odd_parity_bit(data) ^ bad_parity;
    for (i = 0; i < 8; i++) begin
      ones += data[i];
    end
    ones += par_bit;
    return {(ones % 2 == 0), data};
  endfunction

  task automatic wait_cmd_rdy();
    int cycles;
    cycles = 0;
    while (!cmd_rdy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy) begin
      $display("timeout at %0t: cmd_rdy stayed low for %0d cycles", $time, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (i_checker.pending() != 0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (i_checker.pending() != 0) begin
      $display("timeout at %0t: %0d read words did not arrive", $time, i_checker.pending());
      timeouts++;
    end
  endtask

  task automatic send_cmd(input cmd_word_t word);
    wait_cmd_rdy();
    cmd_in  = word;
    cmd_vld = 1'b1;
    i_checker.push_expected(expected_word(word[15:8], 1'b0));
    i_checker.push_expected(expected_word(word[7:0], 1'b0));
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  // cmd_in changes every cycle, only words seen with cmd_rdy high are taken
  task automatic hold_valid_burst(input int words);
    int accepted;
    int cycles;
    accepted = 0;
    cycles   = 0;
    cmd_vld  = 1'b1;
    while (accepted < words && cycles < TIMEOUT) begin
      cmd_in = cmd_word_t'($urandom);
      if (cmd_rdy) begin
        i_checker.push_expected(expected_word(cmd_in[15:8], 1'b0));
        i_checker.push_expected(expected_word(cmd_in[7:0], 1'b0));
        accepted++;
        cycles = 0;
      end else begin
        cycles++;
      end
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    if (accepted < words) begin
      $display("timeout at %0t: only %0d of %0d words accepted", $time, accepted, words);
      timeouts++;
    end
  endtask

  task automatic drive_bit(input logic value);
    gen_line = value;
    repeat (CPB) @(negedge clk);
  endtask

  task automatic send_frame(input uart_byte_t data, input bit bad_parity, input logic stop_val);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(odd_parity_bit(data) ^ bad_parity);
    drive_bit(stop_val);
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    use_gen  = 1'b0;
    gen_line = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    repeat (6) send_cmd(cmd_word_t'($urandom));
    wait_drain();
    wait_cmd_rdy();
    hold_valid_burst(3);
    wait_drain();
    foreach (patterns[i]) begin
      send_cmd(patterns[i]);
    end
    wait_drain();
    wait_cmd_rdy();

    use_gen = 1'b1;
    i_checker.push_expected(expected_word(8'h96, 1'b1));
    send_frame(8'h96, 1'b1, 1'b1);
    i_checker.push_expected(expected_word(8'h07, 1'b1));
    send_frame(8'h07, 1'b1, 1'b1);
    wait_drain();
    // the frame with a low stop bit must be dropped silently
    send_frame(8'h3C, 1'b0, 1'b0);
    i_checker.push_expected(expected_word(8'hC5, 1'b0));
    send_frame(8'hC5, 1'b0, 1'b1);
    wait_drain();

    missing   = i_checker.pending();
    sva_fails = i_uart_top.i_uart_sva.fail_count;
    if (missing != 0) begin
      $display("%0d expected read words never arrived", missing);
    end
    $display("errors: %0d values, %0d assertions, %0d timeouts, %0d missing words",
             i_checker.err_count, sva_fails, timeouts, missing);
    if (i_checker.err_count == 0 && sva_fails == 0 && timeouts == 0 && missing == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/uart_pkg.sv
hw/cmd_pkg.sv
hw/cmd_framer.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
sim/uart_checker.sv
sim/uart_sva.sv
sim/uart_tb.sv
